/* build.f */
+incdir+verilog
verilog/evoTypesPkg.sv
verilog/sampleTypesPkg.sv
verilog/evalBusIf.sv
verilog/sampleStore.sv
verilog/sampleCounter.sv
verilog/evalFsm.sv
verilog/chromCircuit.sv
verilog/errorAccumulator.sv
verilog/evoTop.sv
bench/clockGen.sv
bench/evoTopTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the evoTop testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f build.f --top-module evoTopTb -o evoSim > build.log 2>&1 \
	&& ./obj_dir/evoSim > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"

grep -q "Finished with no errors" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* bench/evoTopTb.sv */
`include "evo_defines.svh"

module evoTopTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_CASES = 7;
	localparam int MODE_MATCH = 0; // expected equals input
	localparam int MODE_INVERT = 1; // expected is inverted input, full mask
	localparam int MODE_RANDOM = 2;
	localparam int NUM_GROUPS = `EVO_NUM_SAMPLES / `EVO_LANES;
	localparam int LOAD_CYCLES = 2 * NUM_GROUPS; // strobe plus ack per group

	typedef struct {
		evoTypesPkg::chromT chrom;
		int count;
		int mode;
	} caseT;

	logic CLOCK_50;
	logic arstN;
	logic writeSample;
	sampleTypesPkg::groupIdxT sampleIndex;
	sampleTypesPkg::laneGroupT sampleGroup;
	logic nextSample;
	evoTypesPkg::chromT chromosome;
	logic [6:0] sequencesToProcess;
	logic startProcessing;
	logic doneProcessingFeedback;
	logic readyToProcess;
	logic doneProcessing;
	evoTypesPkg::errSumsT errorSums;

	caseT cases [NUM_CASES];
	logic [7:0] inSeq [`EVO_NUM_SAMPLES];
	logic [7:0] expByte [`EVO_NUM_SAMPLES];
	logic [7:0] maskByte [`EVO_NUM_SAMPLES];
	int cycleCount = 0;
	int cycleLimit = 0;

	clockGen clockGen_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN)
	);

	evoTop evoTop_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.writeSample(writeSample),
		.sampleIndex(sampleIndex),
		.sampleGroup(sampleGroup),
		.nextSample(nextSample),
		.chromosome(chromosome),
		.sequencesToProcess(sequencesToProcess),
		.startProcessing(startProcessing),
		.doneProcessingFeedback(doneProcessingFeedback),
		.readyToProcess(readyToProcess),
		.doneProcessing(doneProcessing),
		.errorSums(errorSums)
	);

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopped at first error");
	endtask

	always @(posedge CLOCK_50) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			reportFailure($sformatf("timeout: run exceeded %0d cycles", cycleLimit));
		end
	end

	task automatic checkErrSums(input evoTypesPkg::errSumsT actual,
		input evoTypesPkg::errSumsT want, input string name);
		if (actual !== want) begin
			reportFailure($sformatf("FAIL t=%0t %s got %h expected %h",
				$time, name, actual, want));
		end
	endtask

	task automatic checkFlag(input logic actual, input logic want, input string name);
		if (actual !== want) begin
			reportFailure($sformatf("FAIL t=%0t %s got %b expected %b",
				$time, name, actual, want));
		end
	endtask

	// inputs change 10 ns after the rising edge, outputs are settled by then
	task automatic nextCycle();
		@(posedge CLOCK_50);
		#10;
	endtask

	// gene bits: srcA [3:0], srcB [7:4], truth table [11:8]
	function automatic evoTypesPkg::cellOutT modelCells(input evoTypesPkg::chromT chrom,
		input logic [7:0] inByte);
		logic [15:0] node;
		logic [15:0] gene;
		logic va;
		logic vb;
		evoTypesPkg::cellOutT result;
		node = '0;
		node[7:0] = inByte;
		for (int i = 0; i < 8; i++) begin
			gene = chrom[i];
			va = (int'(gene[3:0]) < 8 + i) ? node[gene[3:0]] : 1'b0;
			vb = (int'(gene[7:4]) < 8 + i) ? node[gene[7:4]] : 1'b0;
			result[i] = gene[8 + 2 * int'(vb) + int'(va)];
			node[8 + i] = result[i];
		end
		return result;
	endfunction

	function automatic evoTypesPkg::errSumsT modelSums(input evoTypesPkg::chromT chrom,
		input int count);
		evoTypesPkg::errSumsT sums;
		logic [7:0] wrong;
		sums = '0;
		for (int s = 0; s < count; s++) begin
			wrong = (modelCells(chrom, inSeq[s]) ^ expByte[s]) & maskByte[s];
			for (int j = 0; j < 8; j++) begin
				if (wrong[j] && sums[j] != 16'hFFFF) begin
					sums[j] = sums[j] + 16'd1;
				end
			end
		end
		return sums;
	endfunction

	function automatic evoTypesPkg::chromT identityChrom();
		evoTypesPkg::chromT chrom;
		for (int i = 0; i < 8; i++) begin
			chrom[i] = {4'h0, 4'b1010, 4'h0, 4'(i)}; // table 1010 passes source A
		end
		return chrom;
	endfunction

	function automatic evoTypesPkg::chromT randomChrom();
		evoTypesPkg::chromT chrom;
		for (int i = 0; i < 8; i++) begin
			chrom[i] = 16'($urandom); // sources often past the feed-forward limit
		end
		return chrom;
	endfunction

	task automatic fillCaseTable();
		cases[0] = '{identityChrom(), 16, MODE_MATCH};
		cases[1] = '{identityChrom(), 64, MODE_INVERT};
		cases[2] = '{identityChrom(), 1, MODE_INVERT}; // sums must restart from 0
		cases[3] = '{randomChrom(), 1, MODE_RANDOM};
		cases[4] = '{randomChrom(), 37, MODE_RANDOM};
		cases[5] = '{randomChrom(), 64, MODE_RANDOM};
		cases[6] = '{randomChrom(), 23, MODE_RANDOM};
	endtask

	function automatic int timeoutCycles();
		int total;
		total = 8 + 100; // reset plus margin
		for (int i = 0; i < NUM_CASES; i++) begin
			total += LOAD_CYCLES + cases[i].count + 4 + 5;
		end
		return total;
	endfunction

	task automatic makeSamples(input int mode);
		for (int s = 0; s < `EVO_NUM_SAMPLES; s++) begin
			inSeq[s] = 8'($urandom);
			expByte[s] = (mode == MODE_MATCH) ? inSeq[s] :
				(mode == MODE_INVERT) ? ~inSeq[s] : 8'($urandom);
			maskByte[s] = (mode == MODE_INVERT) ? 8'hFF : 8'($urandom);
		end
	endtask

	task automatic loadSamples();
		sampleTypesPkg::laneGroupT grp;
		int addr;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int k = 0; k < `EVO_LANES; k++) begin
				addr = g * `EVO_LANES + k;
				grp[k].inputSeq = inSeq[addr];
				grp[k].expected = expByte[addr];
				grp[k].validMask = maskByte[addr];
			end
			checkFlag(nextSample, 1'b0, "nextSample");
			writeSample = 1'b1;
			sampleIndex = sampleTypesPkg::groupIdxT'(g);
			sampleGroup = grp;
			nextCycle();
			checkFlag(nextSample, 1'b1, "nextSample"); // ack on the next cycle
			writeSample = 1'b0;
			nextCycle();
			checkFlag(nextSample, 1'b0, "nextSample"); // single pulse only
		end
	endtask

	task automatic runCase(input int idx);
		evoTypesPkg::errSumsT want;
		int count;
		count = cases[idx].count;
		makeSamples(cases[idx].mode);
		loadSamples();
		if (cases[idx].mode == MODE_MATCH) begin
			want = '0;
		end else if (cases[idx].mode == MODE_INVERT) begin
			want = {8{16'(count)}}; // every bit wrong in every sample
		end else begin
			want = modelSums(cases[idx].chrom, count);
		end
		chromosome = cases[idx].chrom;
		sequencesToProcess = 7'(count);
		checkFlag(readyToProcess, 1'b1, "readyToProcess");
		startProcessing = 1'b1;
		nextCycle();
		startProcessing = 1'b0;
		// done must rise exactly count+4 cycles after start is sampled
		for (int c = 0; c <= count + 4; c++) begin
			if (c > 0) begin
				nextCycle();
			end
			checkFlag(doneProcessing, logic'(c == count + 4), "doneProcessing");
			checkFlag(readyToProcess, 1'b0, "readyToProcess");
		end
		checkErrSums(errorSums, want, "errorSums");
		repeat (3) begin
			nextCycle();
			checkFlag(doneProcessing, 1'b1, "doneProcessing"); // held without feedback
			checkFlag(readyToProcess, 1'b0, "readyToProcess");
			checkErrSums(errorSums, want, "errorSums");
		end
		doneProcessingFeedback = 1'b1;
		nextCycle();
		doneProcessingFeedback = 1'b0;
		checkFlag(readyToProcess, 1'b1, "readyToProcess");
		checkFlag(doneProcessing, 1'b0, "doneProcessing");
		checkErrSums(errorSums, want, "errorSums"); // frozen until next start
	endtask

	initial begin
		writeSample = 1'b0;
		sampleIndex = '0;
		sampleGroup = '0;
		chromosome = '0;
		sequencesToProcess = 7'd1;
		startProcessing = 1'b0;
		doneProcessingFeedback = 1'b0;
		void'($urandom(32'ha3d7));
		fillCaseTable();
		cycleLimit = timeoutCycles();
		wait (arstN === 1'b1);
		nextCycle();
		checkFlag(readyToProcess, 1'b1, "readyToProcess");
		checkFlag(doneProcessing, 1'b0, "doneProcessing");
		checkFlag(nextSample, 1'b0, "nextSample");
		for (int i = 0; i < NUM_CASES; i++) begin
			runCase(i);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* bench/clockGen.sv */
module clockGen (
	output logic CLOCK_50,
	output logic arstN
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50; // 100 ns period
	end

	initial begin
		arstN = 1'b0;
		repeat (8) @(posedge CLOCK_50);
		@(negedge CLOCK_50); // release away from the active edge
		arstN = 1'b1;
	end

endmodule

/* verilog/evoTop.sv */
`include "evo_defines.svh"

module evoTop (
	input logic CLOCK_50,
	input logic arstN,
	// sample load from host
	input logic writeSample,
	input sampleTypesPkg::groupIdxT sampleIndex,
	input sampleTypesPkg::laneGroupT sampleGroup,
	output logic nextSample,
	// evaluation
	input evoTypesPkg::chromT chromosome,
	input logic [$clog2(`EVO_NUM_SAMPLES):0] sequencesToProcess,
	input logic startProcessing,
	input logic doneProcessingFeedback,
	output logic readyToProcess,
	output logic doneProcessing,
	output evoTypesPkg::errSumsT errorSums
);

	evalBusIf bus ();

	evoTypesPkg::cellOutT cellOut;
	evoTypesPkg::cellOutT expected;
	evoTypesPkg::cellOutT validMask;
	logic outValid;

	sampleStore sampleStore_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.writeSample(writeSample),
		.sampleIndex(sampleIndex),
		.sampleGroup(sampleGroup),
		.writeEnable(readyToProcess), // loads only between evaluations
		.nextSample(nextSample),
		.bus(bus.store)
	);

	sampleCounter sampleCounter_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.sequencesToProcess(sequencesToProcess),
		.bus(bus.counter)
	);

	evalFsm evalFsm_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.startProcessing(startProcessing),
		.doneProcessingFeedback(doneProcessingFeedback),
		.readyToProcess(readyToProcess),
		.doneProcessing(doneProcessing),
		.bus(bus.fsm)
	);

	chromCircuit chromCircuit_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.chromosome(chromosome),
		.bus(bus.accum),
		.cellOut(cellOut),
		.expected(expected),
		.validMask(validMask),
		.outValid(outValid)
	);

	errorAccumulator errorAccumulator_i (
		.CLOCK_50(CLOCK_50),
		.arstN(arstN),
		.cellOut(cellOut),
		.expected(expected),
		.validMask(validMask),
		.outValid(outValid),
		.bus(bus.accum),
		.errorSums(errorSums)
	);

endmodule

/* verilog/errorAccumulator.sv */
`include "evo_defines.svh"

module errorAccumulator (
	input logic CLOCK_50,
	input logic arstN,
	input evoTypesPkg::cellOutT cellOut,
	input evoTypesPkg::cellOutT expected,
	input evoTypesPkg::cellOutT validMask,
	input logic outValid,
	evalBusIf.accum bus,
	output evoTypesPkg::errSumsT errorSums
);

	evoTypesPkg::cellOutT bitWrong;

	// only masked-in bits count
	assign bitWrong = (cellOut ^ expected) & validMask;

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			errorSums <= '0;
		end else if (bus.clearSums) begin
			errorSums <= '0;
		end else if (outValid) begin
			for (int j = 0; j < `EVO_NUM_CELLS; j++) begin
				// saturate at all ones
				if (bitWrong[j] && (errorSums[j] != '1)) begin
					errorSums[j] <= errorSums[j] + 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/chromCircuit.sv */
`include "evo_defines.svh"

module chromCircuit (
	input logic CLOCK_50,
	input logic arstN,
	input evoTypesPkg::chromT chromosome,
	evalBusIf.accum bus,
	output evoTypesPkg::cellOutT cellOut,
	output evoTypesPkg::cellOutT expected,
	output evoTypesPkg::cellOutT validMask,
	output logic outValid
);

	logic [evoTypesPkg::NUM_NODES-1:0] nodes;
	evoTypesPkg::cellOutT cellVal;

	// cells in order, each sees the inputs and all earlier cells
	always_comb begin
		evoTypesPkg::geneT gene;
		logic bitA;
		logic bitB;
		nodes = '0;
		nodes[`EVO_NUM_CELLS-1:0] = bus.sample.inputSeq;
		for (int i = 0; i < `EVO_NUM_CELLS; i++) begin
			gene = chromosome[i];
			// sources at or past this cell read as 0
			bitA = (int'(gene.srcA) < `EVO_NUM_CELLS + i) ? nodes[gene.srcA] : 1'b0;
			bitB = (int'(gene.srcB) < `EVO_NUM_CELLS + i) ? nodes[gene.srcB] : 1'b0;
			cellVal[i] = gene.truthTable[{bitB, bitA}];
			nodes[`EVO_NUM_CELLS + i] = cellVal[i];
		end
	end

	always_ff @(posedge CLOCK_50) begin
		cellOut <= cellVal;
		expected <= bus.sample.expected; // kept aligned with cellOut
		validMask <= bus.sample.validMask;
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= bus.sampleValid;
		end
	end

endmodule

/* verilog/evalFsm.sv */
module evalFsm (
	input logic CLOCK_50,
	input logic arstN,
	input logic startProcessing,
	input logic doneProcessingFeedback,
	output logic readyToProcess,
	output logic doneProcessing,
	evalBusIf.fsm bus
);

	typedef enum logic [2:0] {
		stIdle,
		stClear,
		stRun,
		stDrain,
		stDone
	} stateT;

	// store, circuit and accumulator stages
	localparam int DRAIN_CYCLES = 3;

	stateT state;
	stateT stateNext;
	logic [1:0] drainCount;

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			drainCount <= '0;
		end else begin
			state <= stateNext;
			if (state == stDrain) begin
				drainCount <= drainCount + 1'b1;
			end else begin
				drainCount <= '0;
			end
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: begin
				if (startProcessing) begin
					stateNext = stClear;
				end
			end
			stClear: stateNext = stRun; // counter and sums cleared here
			stRun: begin
				if (bus.lastAddr) begin
					stateNext = stDrain;
				end
			end
			stDrain: begin
				if (drainCount == 2'(DRAIN_CYCLES - 1)) begin
					stateNext = stDone;
				end
			end
			stDone: begin
				if (doneProcessingFeedback) begin
					stateNext = stIdle;
				end
			end
			default: stateNext = stIdle;
		endcase
	end

	assign readyToProcess = (state == stIdle);
	assign doneProcessing = (state == stDone); // held until feedback
	assign bus.clearSums = (state == stClear);
	assign bus.readEn = (state == stRun); // one address per cycle

	// done comes only once the last read has left the pipeline
	assert property (@(posedge CLOCK_50) disable iff (!arstN)
		$rose(doneProcessing) |-> $past(bus.readEn, DRAIN_CYCLES + 1)
			&& !$past(bus.readEn, DRAIN_CYCLES))
		else $error("done raised with the wrong pipeline drain length");

endmodule

/* verilog/sampleCounter.sv */
`include "evo_defines.svh"

module sampleCounter (
	input logic CLOCK_50,
	input logic arstN,
	input logic [$clog2(`EVO_NUM_SAMPLES):0] sequencesToProcess,
	evalBusIf.counter bus
);

	logic [$clog2(`EVO_NUM_SAMPLES):0] lastIndex;

	assign lastIndex = sequencesToProcess - 1'b1;

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			bus.readAddr <= '0;
		end else if (bus.clearSums) begin
			bus.readAddr <= '0; // start of a new evaluation
		end else if (bus.readEn) begin
			bus.readAddr <= bus.readAddr + 1'b1;
		end
	end

	// terminal flag, fsm stops reading on it
	assign bus.lastAddr = ({1'b0, bus.readAddr} == lastIndex);

	// readout must stop at the end of the store instead of wrapping
	assert property (@(posedge CLOCK_50) disable iff (!arstN)
		(bus.readEn && (int'(bus.readAddr) == `EVO_NUM_SAMPLES - 1)) |=> !bus.readEn)
		else $error("sample address wrapped past store depth");

endmodule

/* verilog/sampleStore.sv */
`include "evo_defines.svh"

module sampleStore (
	input logic CLOCK_50,
	input logic arstN,
	input logic writeSample,
	input sampleTypesPkg::groupIdxT sampleIndex,
	input sampleTypesPkg::laneGroupT sampleGroup,
	input logic writeEnable,
	output logic nextSample,
	evalBusIf.store bus
);

	sampleTypesPkg::sampleT mem [`EVO_NUM_SAMPLES];
	logic writeAccept;

	assign writeAccept = writeSample && writeEnable; // host only writes while idle

	// whole lane group per strobe
	always_ff @(posedge CLOCK_50) begin
		if (writeAccept) begin
			for (int k = 0; k < `EVO_LANES; k++) begin
				mem[sampleTypesPkg::sampleIdxT'(int'(sampleIndex) * `EVO_LANES + k)]
					<= sampleGroup[k];
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (bus.readEn) begin
			bus.sample <= mem[bus.readAddr]; // one cycle read latency
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arstN) begin
		if (!arstN) begin
			nextSample <= 1'b0;
			bus.sampleValid <= 1'b0;
		end else begin
			nextSample <= writeAccept; // ack one cycle after the strobe
			bus.sampleValid <= bus.readEn;
		end
	end

	// host must not load samples during an evaluation
	assert property (@(posedge CLOCK_50) disable iff (!arstN)
		!(writeSample && bus.readEn))
		else $error("writeSample during sample readout");

endmodule

/* verilog/evalBusIf.sv */
interface evalBusIf;

	sampleTypesPkg::sampleIdxT readAddr;
	logic readEn;
	sampleTypesPkg::sampleT sample;
	logic sampleValid; // sample register holds a fresh record
	logic clearSums;
	logic lastAddr; // readAddr at the final sample

	modport fsm (
		output readEn, clearSums,
		input lastAddr
	);

	modport counter (
		input readEn, clearSums,
		output readAddr, lastAddr
	);

	modport store (
		input readAddr, readEn,
		output sample, sampleValid
	);

	modport accum (
		input sample, sampleValid, clearSums
	);

endinterface

/* verilog/sampleTypesPkg.sv */
`include "evo_defines.svh"

package sampleTypesPkg;

	localparam int IDX_WIDTH = $clog2(`EVO_NUM_SAMPLES);
	localparam int GROUP_WIDTH = $clog2(`EVO_NUM_SAMPLES / `EVO_LANES);

	// one training sample, a byte per field
	typedef struct packed {
		logic [`EVO_NUM_CELLS-1:0] inputSeq;
		logic [`EVO_NUM_CELLS-1:0] expected;
		logic [`EVO_NUM_CELLS-1:0] validMask; // set bits are scored
	} sampleT;

	// lane k goes to address group*LANES+k
	typedef sampleT [`EVO_LANES-1:0] laneGroupT;

	typedef logic [IDX_WIDTH-1:0] sampleIdxT;

	typedef logic [GROUP_WIDTH-1:0] groupIdxT;

endpackage

/* verilog/evoTypesPkg.sv */
`include "evo_defines.svh"

package evoTypesPkg;

	// input byte plus one node per cell
	localparam int NUM_NODES = 2 * `EVO_NUM_CELLS;
	localparam int SRC_WIDTH = $clog2(NUM_NODES);

	typedef struct packed {
		logic [`EVO_GENE_WIDTH-3*SRC_WIDTH-1:0] unused;
		logic [SRC_WIDTH-1:0] truthTable; // indexed by {srcB, srcA}
		logic [SRC_WIDTH-1:0] srcB;
		logic [SRC_WIDTH-1:0] srcA;
	} geneT;

	typedef geneT [`EVO_NUM_CELLS-1:0] chromT;

	// bit i is the value of cell i
	typedef logic [`EVO_NUM_CELLS-1:0] cellOutT;

	typedef logic [`EVO_ERR_WIDTH-1:0] errCountT;
	typedef errCountT [`EVO_NUM_CELLS-1:0] errSumsT; // saturating, one per output bit

endpackage

/* verilog/evo_defines.svh */
`ifndef EVO_DEFINES_SVH
`define EVO_DEFINES_SVH

// logic cells, one per output bit
`define EVO_NUM_CELLS 8

// bits per gene
`define EVO_GENE_WIDTH 16

// depth of the sample store
`define EVO_NUM_SAMPLES 64

// samples written per host strobe
`define EVO_LANES 4

// width of each error counter
`define EVO_ERR_WIDTH 16

`endif
